// ==== include/cache_defines.svh ====
// Geometry and sizing constants for the blocking cache and its backing memory.
// Include this file wherever a width or size is needed.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Processor side
`define CACHE_ADDR_W    32
`define CACHE_DATA_W    32
`define CACHE_OPQ_W     8

// Cache geometry of 8 sets by 2 ways with 16-byte lines
`define CACHE_LINE_W    128
`define CACHE_NUM_SETS  8
`define CACHE_IDX_W     3
`define CACHE_OFS_W     4
`define CACHE_TAG_W     25

// Backing memory
`define MEM_NUM_LINES   64
`define MEM_LATENCY     2

`endif

// ==== logic/cache_pkg.sv ====
// Message, state and control types shared by the cache, its controller and datapath,
// and the backing memory.
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

  typedef enum logic [1:0] {
    req_read  = 2'd0,
    req_write = 2'd1,
    req_init  = 2'd2
  } req_type_e;

  // Processor side messages
  typedef struct packed {
    logic [`CACHE_OPQ_W-1:0]  opaque;
    req_type_e                req_type;
    logic                     domain;
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] data;
  } cache_req_t;

  typedef struct packed {
    logic [`CACHE_OPQ_W-1:0]  opaque;
    req_type_e                req_type;
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] data;
  } cache_resp_t;

  // Memory side messages carry one full line
  typedef struct packed {
    logic                                 write;
    logic [`CACHE_ADDR_W-`CACHE_OFS_W-1:0] addr;
    logic [`CACHE_LINE_W-1:0]             data;
  } mem_req_t;

  typedef struct packed {
    logic [`CACHE_LINE_W-1:0] data;
  } mem_resp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_tag_check,
    st_evict_req,
    st_evict_wait,
    st_refill_req,
    st_refill_wait,
    st_access,
    st_resp
  } ctrl_state_e;

  // Controller to datapath
  typedef struct packed {
    logic req_en;
    logic refill_en;
    logic way_sel;
    logic tag_wen;
    logic data_wen;
    logic word_wen;
    logic dirty_set;
    logic dirty_clr;
    logic lru_update;
    logic evict_addr_sel;
  } ctrl_t;

  // Datapath to controller
  typedef struct packed {
    req_type_e req_type;
    logic      hit_way0;
    logic      hit_way1;
    logic      victim_way;
    logic      victim_dirty;
    logic      victim_valid;
  } status_t;

endpackage

`default_nettype wire

// ==== logic/line_memory.sv ====
// Line-wide backing memory for the cache. Accepts one request at a time and
// answers after a fixed latency; contents clear to zero on reset.
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module line_memory (
  input  logic                 clk,
  input  logic                 arst_n,
  input  cache_pkg::mem_req_t  memreq,
  input  logic                 memreq_val,
  output logic                 memreq_rdy,
  output cache_pkg::mem_resp_t memresp,
  output logic                 memresp_val,
  input  logic                 memresp_rdy,
  input  logic                 mem_write
);
  import cache_pkg::*;

  localparam int idx_w = $clog2(`MEM_NUM_LINES);
  localparam int cnt_w = $clog2(`MEM_LATENCY + 1);

  logic [`CACHE_LINE_W-1:0] mem [`MEM_NUM_LINES];
  logic [idx_w-1:0]         line_idx;
  logic                     busy_q;
  logic                     resp_val_q;
  logic [cnt_w-1:0]         cnt_q;
  logic                     accept;
  mem_resp_t                resp_q;

  assign line_idx   = memreq.addr[idx_w-1:0];
  assign memreq_rdy = !busy_q && !resp_val_q;
  assign accept     = memreq_val && memreq_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `MEM_NUM_LINES; i++) begin
        mem[i] <= '0;
      end
      busy_q     <= 1'b0;
      resp_val_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= cnt_w'(`MEM_LATENCY - 1);
        if (mem_write) mem[line_idx] <= memreq.data;
      end else if (busy_q) begin
        // Latency countdown
        if (cnt_q == '0) begin
          busy_q     <= 1'b0;
          resp_val_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
      if (resp_val_q && memresp_rdy) resp_val_q <= 1'b0;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk) begin
    if (accept) resp_q.data <= mem_write ? '0 : mem[line_idx];
  end

  assign memresp     = resp_q;
  assign memresp_val = resp_val_q;

endmodule

`default_nettype wire

// ==== logic/cache_ctrl.sv ====
// Blocking cache controller. Walks each request through tag check, optional
// writeback and refill, array update and response, driving all handshakes.
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                cachereq_val,
  output logic                cachereq_rdy,
  output logic                cacheresp_val,
  input  logic                cacheresp_rdy,
  output logic                memreq_val,
  input  logic                memreq_rdy,
  input  logic                memresp_val,
  output logic                memresp_rdy,
  output cache_pkg::ctrl_t    ctrl,
  input  cache_pkg::status_t  status,
  output logic                mem_write
);
  import cache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        way_q;
  logic        miss_q;
  logic        hit;
  logic        chk_way;
  logic        write_like;

  // A hit needs both tag and domain to match
  assign hit        = status.hit_way0 | status.hit_way1;
  assign chk_way    = hit ? status.hit_way1 : status.victim_way;
  assign write_like = (status.req_type != req_read);

  //----------------------------------------------------------------------
  // State register
  //----------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      way_q   <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Way and outcome are fixed for the rest of the request
      if (state_q == st_tag_check) begin
        way_q  <= chk_way;
        miss_q <= !hit;
      end
    end
  end

  //----------------------------------------------------------------------
  // Next state
  //----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (cachereq_val) state_d = st_tag_check;
      end
      st_tag_check: begin
        if (hit) begin
          state_d = st_access;
        end else if (status.victim_valid && status.victim_dirty) begin
          state_d = st_evict_req;
        end else if (status.req_type == req_init) begin
          state_d = st_access;
        end else begin
          state_d = st_refill_req;
        end
      end
      st_evict_req: begin
        if (memreq_rdy) state_d = st_evict_wait;
      end
      st_evict_wait: begin
        // Init allocates without fetching the line
        if (memresp_val) begin
          state_d = (status.req_type == req_init) ? st_access : st_refill_req;
        end
      end
      st_refill_req: begin
        if (memreq_rdy) state_d = st_refill_wait;
      end
      st_refill_wait: begin
        if (memresp_val) state_d = st_access;
      end
      st_access: begin
        state_d = st_resp;
      end
      st_resp: begin
        if (cacheresp_rdy) state_d = st_idle;
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  //----------------------------------------------------------------------
  // Outputs per state
  //----------------------------------------------------------------------

  always_comb begin
    ctrl          = '0;
    ctrl.way_sel  = way_q;
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    case (state_q)
      st_idle: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = cachereq_val;
      end
      st_evict_req: begin
        memreq_val          = 1'b1;
        ctrl.evict_addr_sel = 1'b1;
      end
      st_evict_wait: begin
        memresp_rdy = 1'b1;
      end
      st_refill_req: begin
        memreq_val = 1'b1;
      end
      st_refill_wait: begin
        memresp_rdy    = 1'b1;
        ctrl.refill_en = memresp_val;
      end
      st_access: begin
        // Allocation rewrites tag and line while stores merge in the word
        ctrl.data_wen   = miss_q | write_like;
        ctrl.word_wen   = write_like;
        ctrl.tag_wen    = miss_q;
        ctrl.dirty_set  = write_like;
        ctrl.dirty_clr  = miss_q;
        ctrl.lru_update = 1'b1;
      end
      st_resp: begin
        cacheresp_val = 1'b1;
      end
      default: ;
    endcase
  end

  // Only writebacks go out as memory writes
  assign mem_write = (state_q == st_evict_req);

endmodule

`default_nettype wire

// ==== logic/cache_dpath.sv ====
// Blocking cache datapath. Holds the tag, domain, valid, dirty and LRU state
// with the data array, and formats the response and memory request fields.
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_dpath (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  cache_pkg::cache_req_t                 cachereq,
  output cache_pkg::cache_resp_t                cacheresp,
  output logic [`CACHE_ADDR_W-`CACHE_OFS_W-1:0] memreq_addr,
  output logic [`CACHE_LINE_W-1:0]              memreq_data,
  input  cache_pkg::mem_resp_t                  memresp,
  input  cache_pkg::ctrl_t                      ctrl,
  output cache_pkg::status_t                    status
);
  import cache_pkg::*;

  localparam int word_sel_w = `CACHE_OFS_W - 2;

  cache_req_t                      req_q;
  logic [`CACHE_TAG_W-1:0]         req_tag;
  logic [`CACHE_IDX_W-1:0]         req_idx;
  logic [word_sel_w-1:0]           req_word;

  // Per-way arrays
  logic [`CACHE_TAG_W-1:0]         tag_array  [2][`CACHE_NUM_SETS];
  logic                            dom_array  [2][`CACHE_NUM_SETS];
  logic [`CACHE_LINE_W-1:0]        data_array [2][`CACHE_NUM_SETS];
  logic [1:0][`CACHE_NUM_SETS-1:0] valid_q;
  logic [1:0][`CACHE_NUM_SETS-1:0] dirty_q;
  logic [`CACHE_NUM_SETS-1:0]      lru_q;

  logic [1:0]                      tag_match;
  logic [1:0]                      hit_way;
  logic                            victim_way;
  logic [`CACHE_LINE_W-1:0]        refill_q;
  logic [`CACHE_LINE_W-1:0]        line_rd;
  logic [`CACHE_LINE_W-1:0]        line_base;
  logic [`CACHE_LINE_W-1:0]        line_wr;
  logic                            chk_q;
  logic                            hit_q;

  assign req_tag  = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign req_idx  = req_q.addr[`CACHE_OFS_W +: `CACHE_IDX_W];
  assign req_word = req_q.addr[`CACHE_OFS_W-1:2];

  //----------------------------------------------------------------------
  // Tag check
  //----------------------------------------------------------------------

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      tag_match[w] = valid_q[w][req_idx] && (tag_array[w][req_idx] == req_tag);
      hit_way[w]   = tag_match[w] && (dom_array[w][req_idx] == req_q.domain);
    end
  end

  // A resident tag of the other domain is the victim, so no address lives twice
  always_comb begin
    if (tag_match[0]) begin
      victim_way = 1'b0;
    end else if (tag_match[1]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru_q[req_idx];
    end
  end

  assign status.req_type     = req_q.req_type;
  assign status.hit_way0     = hit_way[0];
  assign status.hit_way1     = hit_way[1];
  assign status.victim_way   = victim_way;
  assign status.victim_dirty = dirty_q[victim_way][req_idx];
  assign status.victim_valid = valid_q[victim_way][req_idx];

  //----------------------------------------------------------------------
  // Line merge and array writes
  //----------------------------------------------------------------------

  assign line_rd   = data_array[ctrl.way_sel][req_idx];
  assign line_base = ctrl.tag_wen ? refill_q : line_rd;

  always_comb begin
    line_wr = line_base;
    if (ctrl.word_wen) begin
      line_wr[req_word*`CACHE_DATA_W +: `CACHE_DATA_W] = req_q.data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.req_en) req_q <= cachereq;
    // Zero line for an init that allocates without refill
    if (ctrl.refill_en) begin
      refill_q <= memresp.data;
    end else if (ctrl.req_en) begin
      refill_q <= '0;
    end
    if (ctrl.data_wen) data_array[ctrl.way_sel][req_idx] <= line_wr;
    if (ctrl.tag_wen) begin
      tag_array[ctrl.way_sel][req_idx] <= req_tag;
      dom_array[ctrl.way_sel][req_idx] <= req_q.domain;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
      chk_q   <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      // Tag check is always the cycle after the request is loaded
      chk_q <= ctrl.req_en;
      if (chk_q) hit_q <= |hit_way;
      if (ctrl.tag_wen) valid_q[ctrl.way_sel][req_idx] <= 1'b1;
      if (ctrl.dirty_set) begin
        dirty_q[ctrl.way_sel][req_idx] <= 1'b1;
      end else if (ctrl.dirty_clr) begin
        dirty_q[ctrl.way_sel][req_idx] <= 1'b0;
      end
      // LRU bit names the way to replace next
      if (ctrl.lru_update) lru_q[req_idx] <= !ctrl.way_sel;
    end
  end

  //----------------------------------------------------------------------
  // Messages
  //----------------------------------------------------------------------

  assign cacheresp.opaque   = req_q.opaque;
  assign cacheresp.req_type = req_q.req_type;
  assign cacheresp.hit      = hit_q;
  assign cacheresp.data     = (req_q.req_type == req_read) ?
                              line_rd[req_word*`CACHE_DATA_W +: `CACHE_DATA_W] : '0;

  assign memreq_addr = ctrl.evict_addr_sel ? {tag_array[ctrl.way_sel][req_idx], req_idx}
                                           : req_q.addr[`CACHE_ADDR_W-1:`CACHE_OFS_W];
  assign memreq_data = line_rd;

endmodule

`default_nettype wire

// ==== logic/blocking_cache.sv ====
// Two-way blocking data cache with a domain bit per line. Joins the controller
// and datapath and presents word-wide processor and line-wide memory ports.
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module blocking_cache (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cache_pkg::cache_req_t  cachereq,
  input  logic                   cachereq_val,
  output logic                   cachereq_rdy,
  output cache_pkg::cache_resp_t cacheresp,
  output logic                   cacheresp_val,
  input  logic                   cacheresp_rdy,
  output cache_pkg::mem_req_t    memreq,
  output logic                   memreq_val,
  input  logic                   memreq_rdy,
  input  cache_pkg::mem_resp_t   memresp,
  input  logic                   memresp_val,
  output logic                   memresp_rdy
);
  import cache_pkg::*;

  ctrl_t                                 ctrl;
  status_t                               status;
  logic                                  mem_write;
  logic [`CACHE_ADDR_W-`CACHE_OFS_W-1:0] memreq_addr;
  logic [`CACHE_LINE_W-1:0]              memreq_data;

  // Handshakes

  cache_ctrl i_cache_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .ctrl          (ctrl),
    .status        (status),
    .mem_write     (mem_write)
  );

  // Messages

  cache_dpath i_cache_dpath (
    .clk         (clk),
    .arst_n      (arst_n),
    .cachereq    (cachereq),
    .cacheresp   (cacheresp),
    .memreq_addr (memreq_addr),
    .memreq_data (memreq_data),
    .memresp     (memresp),
    .ctrl        (ctrl),
    .status      (status)
  );

  assign memreq = '{write: mem_write, addr: memreq_addr, data: memreq_data};

endmodule

`default_nettype wire

// ==== logic/cache_subsystem.sv ====
// Top level that joins the blocking cache to its line-wide backing memory.
`timescale 1ns/1ns
`default_nettype none

module cache_subsystem (
  input  logic                   clk,
  input  logic                   arst_n,
  input  cache_pkg::cache_req_t  cachereq,
  input  logic                   cachereq_val,
  output logic                   cachereq_rdy,
  output cache_pkg::cache_resp_t cacheresp,
  output logic                   cacheresp_val,
  input  logic                   cacheresp_rdy
);
  import cache_pkg::*;

  mem_req_t  memreq;
  logic      memreq_val;
  logic      memreq_rdy;
  mem_resp_t memresp;
  logic      memresp_val;
  logic      memresp_rdy;

  blocking_cache i_blocking_cache (
    .clk           (clk),
    .arst_n        (arst_n),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq        (memreq),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp       (memresp),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy)
  );

  line_memory i_line_memory (
    .clk         (clk),
    .arst_n      (arst_n),
    .memreq      (memreq),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memresp     (memresp),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy),
    .mem_write   (memreq.write)
  );

endmodule

`default_nettype wire

// ==== testbench/cache_tb.sv ====
// Testbench for the cache subsystem. Reads request cases from a data file,
// issues them one at a time and checks each response under random back-pressure.
`timescale 1ns/1ns
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int num_cases      = 24;
  localparam int case_fields    = 6;
  localparam int clk_half       = 20;
  localparam int drive_delay    = 2;
  localparam int reset_cycles   = 3;
  localparam int timeout_cycles = num_cases * 40;

  logic        clk;
  logic        arst_n;
  cache_req_t  cachereq;
  logic        cachereq_val;
  logic        cachereq_rdy;
  cache_resp_t cacheresp;
  logic        cacheresp_val;
  logic        cacheresp_rdy;

  // Each case is type, domain, address, data, expected data and expected hit
  logic [31:0] case_words [num_cases*case_fields];
  logic [31:0] rng_state;
  int          cycle_cnt = 0;

  cache_subsystem i_cache_subsystem (
    .clk           (clk),
    .arst_n        (arst_n),
    .cachereq      (cachereq),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp     (cacheresp),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy)
  );

  always #clk_half clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Test failed");
      $fatal(1, "Timeout after %0d cycles before all cases finished", cycle_cnt);
    end
  end

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Called at a drive point; returns at the drive point after the response
  task automatic run_case(input int n);
    int          base;
    int          hold;
    req_type_e   exp_type;
    cache_resp_t first;
    base     = n * case_fields;
    exp_type = req_type_e'(case_words[base][1:0]);

    cachereq.opaque   = 8'(n);
    cachereq.req_type = exp_type;
    cachereq.domain   = case_words[base+1][0];
    cachereq.addr     = case_words[base+2];
    cachereq.data     = case_words[base+3];
    cachereq_val      = 1'b1;

    // Request is held until the cache takes it
    do @(negedge clk); while (!cachereq_rdy);
    @(posedge clk);
    #drive_delay;
    cachereq_val = 1'b0;

    rng_state = next_random(rng_state);
    hold      = int'(rng_state[1:0]);
    if (hold == 0) cacheresp_rdy = 1'b1;

    do @(negedge clk); while (!cacheresp_val);
    first = cacheresp;

    // Stalled response must not change
    if (hold != 0) begin
      repeat (hold - 1) begin
        @(negedge clk);
        compare_field("cacheresp_val", 64'(cacheresp_val), 64'd1);
        compare_field("cacheresp", 64'(cacheresp), 64'(first));
      end
      @(posedge clk);
      #drive_delay;
      cacheresp_rdy = 1'b1;
      @(negedge clk);
      compare_field("cacheresp_val", 64'(cacheresp_val), 64'd1);
      compare_field("cacheresp", 64'(cacheresp), 64'(first));
    end
    @(posedge clk);
    #drive_delay;
    cacheresp_rdy = 1'b0;

    compare_field("cacheresp.opaque", 64'(first.opaque), 64'(8'(n)));
    compare_field("cacheresp.req_type", 64'(first.req_type), 64'(exp_type));
    compare_field("cacheresp.hit", 64'(first.hit), 64'(case_words[base+5][0]));
    compare_field("cacheresp.data", 64'(first.data), 64'(case_words[base+4]));
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------

  initial begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b0;
    rng_state     = 32'hac8dce3c;

    $readmemh("testbench/cache_cases.txt", case_words);
    assert (!$isunknown(case_words[num_cases*case_fields-1])) else begin
      $display("The case file could not be read or holds too few cases");
      $display("Test failed");
      $fatal(1, "Case file unusable");
    end

    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    arst_n = 1'b1;

    @(negedge clk);
    compare_field("cachereq_rdy", 64'(cachereq_rdy), 64'd1);
    compare_field("cacheresp_val", 64'(cacheresp_val), 64'd0);
    @(posedge clk);
    #drive_delay;

    for (int n = 0; n < num_cases; n++) begin
      run_case(n);
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
logic/cache_pkg.sv
logic/line_memory.sv
logic/cache_ctrl.sv
logic/cache_dpath.sv
logic/blocking_cache.sv
logic/cache_subsystem.sv
testbench/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cache_tb

sim_out=$(./obj_dir/Vcache_tb 2>&1 || true)
echo "$sim_out"
if grep -q "^Test passed$" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== testbench/cache_cases.txt ====
// type(0 rd,1 wr,2 init) domain addr data exp_data exp_hit
// one case per line, all fields hex
1 0 00000010 deadbeef 00000000 0
0 0 00000010 00000000 deadbeef 1
2 0 00000024 11111111 00000000 0
0 0 00000028 00000000 00000000 1
0 0 00000024 00000000 11111111 1
0 0 00000130 00000000 00000000 0
1 0 00000050 aaaa0001 00000000 0
1 0 000000d4 bbbb0002 00000000 0
1 0 00000158 cccc0003 00000000 0
0 0 00000050 00000000 aaaa0001 0
0 0 000000d4 00000000 bbbb0002 0
0 0 00000158 00000000 cccc0003 0
1 0 0000001c 12345678 00000000 1
0 1 0000001c 00000000 12345678 0
0 1 0000001c 00000000 12345678 1
0 0 00000010 00000000 deadbeef 0
1 1 00000134 0badf00d 00000000 0
0 1 00000134 00000000 0badf00d 1
1 0 000002a0 55aa55aa 00000000 0
2 0 000003a4 77777777 00000000 0
0 0 00000024 00000000 11111111 0
0 0 000003a8 00000000 00000000 1
0 0 000002a0 00000000 55aa55aa 0
0 0 000003a4 00000000 77777777 1
